/* compile.f */
hdl/cp0RegPkg.sv
hdl/cp0ExcPkg.sv
hdl/cp0ExcDecode.sv
hdl/cp0Timer.sv
hdl/cp0RegBlock.sv
hdl/cp0Top.sv
test/cp0Tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := cp0Tb
FILELIST  := compile.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASSMSG   := TEST OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASSMSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* test/cp0Tb.sv */
// CP0 table-driven testbench
`timescale 1ns/1ps

module cp0Tb;

    localparam cp0RegPkg::wordT PrIdValue = 32'h00018000;
    localparam logic [2:0]      K0Reset   = 3'd2;
    localparam cp0RegPkg::wordT TimerAhead = 32'd4;

    localparam int ActWrite = 0;
    localparam int ActRead  = 1;
    localparam int ActExc   = 2;
    localparam int ActIdle  = 3;
    localparam int ActOut   = 4;  // expVal[1] timerIntO, expVal[0] usermodeO
    localparam int ActWait  = 5;
    localparam int ActHwInt = 6;

    typedef struct {
        string              name;
        int                 act;
        cp0RegPkg::regAddrT addr;
        cp0RegPkg::wordT    data;
        cp0RegPkg::wordT    expVal;
        cp0ExcPkg::excKindT kind;
        cp0RegPkg::wordT    pc;
        logic               inSlot;
        cp0RegPkg::wordT    badAddr;
        cp0ExcPkg::cpNumT   cpNum;
        logic               withWrite;
    } stepT;

    logic                         clk;
    logic                         rst;
    cp0RegPkg::regAddrT           regAddrI;
    logic                         writeEnI;
    cp0RegPkg::wordT              wdataI;
    cp0RegPkg::wordT              rdataO;
    logic                         excValidI;
    cp0ExcPkg::excKindT           excKindI;
    cp0RegPkg::wordT              pcI;
    logic                         inSlotI;
    cp0RegPkg::wordT              badAddrI;
    cp0ExcPkg::cpNumT             cpNumI;
    logic [cp0RegPkg::HwIntW-1:0] hwIntI;
    logic                         usermodeO;
    logic                         timerIntO;

    stepT steps[$];
    int   errorCount = 0;
    int   checkCount = 0;
    int   cycleCount = 0;
    int   cycleLimit = 400;

    // Expected Cause fields, updated as the table grows
    logic       bdM, ivM;
    logic [1:0] ceM;
    logic [7:0] ipM;
    logic [4:0] codeM;

    cp0Top #(.PrIdValue(PrIdValue), .K0Reset(K0Reset)) u_cp0Top (
        .clk(clk), .rst(rst), .regAddrI(regAddrI), .writeEnI(writeEnI), .wdataI(wdataI),
        .rdataO(rdataO), .excValidI(excValidI), .excKindI(excKindI), .pcI(pcI),
        .inSlotI(inSlotI), .badAddrI(badAddrI), .cpNumI(cpNumI), .hwIntI(hwIntI),
        .usermodeO(usermodeO), .timerIntO(timerIntO)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic cp0RegPkg::wordT causeValue();
        cp0RegPkg::wordT w;
        w = '0;
        w[cp0RegPkg::CauseBd] = bdM;
        w[cp0RegPkg::CauseCeHi:cp0RegPkg::CauseCeLo] = ceM;
        w[cp0RegPkg::CauseIv] = ivM;
        w[cp0RegPkg::CauseIpHi:cp0RegPkg::CauseIpLo] = ipM;
        w[cp0RegPkg::CauseCodeHi:cp0RegPkg::CauseCodeLo] = codeM;
        return w;
    endfunction

    function automatic void pushStep(string name, int act, cp0RegPkg::regAddrT addr,
                                     cp0RegPkg::wordT data, cp0RegPkg::wordT expVal,
                                     cp0ExcPkg::excKindT kind, cp0RegPkg::wordT pc,
                                     logic inSlot, cp0RegPkg::wordT badAddr,
                                     cp0ExcPkg::cpNumT cpNum, logic withWrite);
        stepT s;
        s.name = name;
        s.act = act;
        s.addr = addr;
        s.data = data;
        s.expVal = expVal;
        s.kind = kind;
        s.pc = pc;
        s.inSlot = inSlot;
        s.badAddr = badAddr;
        s.cpNum = cpNum;
        s.withWrite = withWrite;
        steps.push_back(s);
    endfunction

    function automatic void addStep(string name, int act, cp0RegPkg::regAddrT addr,
                                    cp0RegPkg::wordT data, cp0RegPkg::wordT expVal);
        pushStep(name, act, addr, data, expVal, cp0ExcPkg::ExcIntr, '0, 1'b0, '0, 2'd0, 1'b0);
    endfunction

    function automatic void addExc(string name, cp0ExcPkg::excKindT kind, cp0RegPkg::wordT pc,
                                   logic inSlot, cp0RegPkg::wordT badAddr,
                                   cp0ExcPkg::cpNumT cpNum);
        pushStep(name, ActExc, '0, '0, '0, kind, pc, inSlot, badAddr, cpNum, 1'b0);
    endfunction

    function automatic void buildTable();
        cp0RegPkg::wordT r, pcA, pcB, badA, badB, cnt, statusMask, userStatus;
        statusMask = '0;
        statusMask[cp0RegPkg::StatusCu0] = 1'b1;
        statusMask[cp0RegPkg::StatusBev] = 1'b1;
        statusMask[cp0RegPkg::StatusImHi:cp0RegPkg::StatusImLo] = '1;
        statusMask[cp0RegPkg::StatusUm] = 1'b1;
        statusMask[cp0RegPkg::StatusErl] = 1'b1;
        statusMask[cp0RegPkg::StatusExl] = 1'b1;
        statusMask[cp0RegPkg::StatusIe] = 1'b1;
        userStatus = 32'd1 << cp0RegPkg::StatusUm;
        {bdM, ivM, ceM, ipM, codeM} = '0;

        addStep("reset status", ActRead, cp0RegPkg::RegStatus, '0, 32'h00400004);
        addStep("reset config", ActRead, cp0RegPkg::RegConfig, '0, 32'h80000082);
        addStep("reset prid", ActRead, cp0RegPkg::RegPrId, '0, PrIdValue);
        addStep("reset cause", ActRead, cp0RegPkg::RegCause, '0, '0);
        addStep("reset epc", ActRead, cp0RegPkg::RegEpc, '0, '0);
        addStep("unlisted reg", ActRead, 5'd3, '0, '0);
        addStep("reset outputs", ActOut, '0, '0, 32'd0);

        // Random words through the write masks
        r = $urandom();
        addStep("status write", ActWrite, cp0RegPkg::RegStatus, r, '0);
        addStep("status mask", ActRead, cp0RegPkg::RegStatus, '0, r & statusMask);
        r = $urandom();
        addStep("cause write", ActWrite, cp0RegPkg::RegCause, r, '0);
        ivM = r[cp0RegPkg::CauseIv];
        ipM[1:0] = r[cp0RegPkg::CauseIpLo+1:cp0RegPkg::CauseIpLo];
        addStep("cause mask", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        r = $urandom();
        addStep("epc write", ActWrite, cp0RegPkg::RegEpc, r, '0);
        addStep("epc readback", ActRead, cp0RegPkg::RegEpc, '0, r);
        r = $urandom();
        addStep("config write", ActWrite, cp0RegPkg::RegConfig, r, '0);
        addStep("config mask", ActRead, cp0RegPkg::RegConfig, '0,
                (32'h80000082 & ~32'h7) | {29'd0, r[2:0]});
        addStep("badvaddr write", ActWrite, cp0RegPkg::RegBadVAddr, $urandom(), '0);
        addStep("badvaddr kept", ActRead, cp0RegPkg::RegBadVAddr, '0, '0);
        addStep("prid write", ActWrite, cp0RegPkg::RegPrId, $urandom(), '0);
        addStep("prid kept", ActRead, cp0RegPkg::RegPrId, '0, PrIdValue);
        addStep("user status", ActWrite, cp0RegPkg::RegStatus, userStatus, '0);
        addStep("user mode on", ActOut, '0, '0, 32'd1);

        // Entry, nesting and return
        pcA = $urandom() & 32'hfffffffc;
        pcB = pcA + 32'h100;
        addExc("ov in slot", cp0ExcPkg::ExcOv, pcA, 1'b1, '0, 2'd0);
        bdM = 1'b1;
        codeM = cp0ExcPkg::CodeOv;
        addStep("ov epc", ActRead, cp0RegPkg::RegEpc, '0, pcA - 32'd4);
        addStep("ov cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addStep("ov exl", ActRead, cp0RegPkg::RegStatus, '0,
                userStatus | (32'd1 << cp0RegPkg::StatusExl));
        addStep("ov user off", ActOut, '0, '0, 32'd0);
        addExc("nested syscall", cp0ExcPkg::ExcSysCall, pcB, 1'b0, '0, 2'd0);
        codeM = cp0ExcPkg::CodeSys;
        addStep("nested epc kept", ActRead, cp0RegPkg::RegEpc, '0, pcA - 32'd4);
        addStep("nested cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addExc("eret", cp0ExcPkg::ExcEret, '0, 1'b0, '0, 2'd0);
        addStep("eret status", ActRead, cp0RegPkg::RegStatus, '0, userStatus);
        addStep("eret user on", ActOut, '0, '0, 32'd1);
        pushStep("bp with write", ActExc, cp0RegPkg::RegEpc, $urandom(), '0,
                 cp0ExcPkg::ExcBp, pcB, 1'b0, '0, 2'd0, 1'b1);
        bdM = 1'b0;
        codeM = cp0ExcPkg::CodeBp;
        addStep("write lost", ActRead, cp0RegPkg::RegEpc, '0, pcB);
        addStep("bp cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addExc("eret", cp0ExcPkg::ExcEret, '0, 1'b0, '0, 2'd0);

        // BadVAddr and CE captures
        badA = $urandom();
        badB = $urandom();
        addExc("adel", cp0ExcPkg::ExcAdEL, pcA, 1'b0, badA, 2'd1);
        codeM = cp0ExcPkg::CodeAdEL;
        addStep("adel badvaddr", ActRead, cp0RegPkg::RegBadVAddr, '0, badA);
        addStep("adel cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addExc("eret", cp0ExcPkg::ExcEret, '0, 1'b0, '0, 2'd0);
        addExc("ades", cp0ExcPkg::ExcAdES, pcA, 1'b0, badB, 2'd1);
        codeM = cp0ExcPkg::CodeAdES;
        addStep("ades badvaddr", ActRead, cp0RegPkg::RegBadVAddr, '0, badB);
        addStep("ades cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addExc("eret", cp0ExcPkg::ExcEret, '0, 1'b0, '0, 2'd0);
        addExc("cpu", cp0ExcPkg::ExcCpU, pcA, 1'b0, badA, 2'd2);
        ceM = 2'd2;
        codeM = cp0ExcPkg::CodeCpU;
        addStep("cpu badvaddr kept", ActRead, cp0RegPkg::RegBadVAddr, '0, badB);
        addStep("cpu cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addExc("eret", cp0ExcPkg::ExcEret, '0, 1'b0, '0, 2'd0);
        addExc("ri", cp0ExcPkg::ExcRi, pcB, 1'b0, badA, 2'd3);
        codeM = cp0ExcPkg::CodeRi;
        addStep("ri badvaddr kept", ActRead, cp0RegPkg::RegBadVAddr, '0, badB);
        addStep("ri cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addExc("trap nested", cp0ExcPkg::ExcTrap, pcA, 1'b1, badA, 2'd1);
        codeM = cp0ExcPkg::CodeTr;
        addStep("trap cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addExc("eret", cp0ExcPkg::ExcEret, '0, 1'b0, '0, 2'd0);
        addExc("intr", cp0ExcPkg::ExcIntr, pcA, 1'b0, '0, 2'd0);
        codeM = cp0ExcPkg::CodeInt;
        addStep("intr epc", ActRead, cp0RegPkg::RegEpc, '0, pcA);
        addStep("intr cause", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addExc("eret", cp0ExcPkg::ExcEret, '0, 1'b0, '0, 2'd0);

        // Count runs one per edge after a write
        cnt = $urandom();
        addStep("count write", ActWrite, cp0RegPkg::RegCount, cnt, '0);
        addStep("count idle", ActIdle, '0, 32'd5, '0);
        addStep("count read", ActRead, cp0RegPkg::RegCount, '0, cnt + 32'd5);
        cnt = $urandom() & 32'h7fffffff;
        addStep("timer count", ActWrite, cp0RegPkg::RegCount, cnt, '0);
        addStep("timer compare", ActWrite, cp0RegPkg::RegCompare, cnt + 32'd1 + TimerAhead, '0);
        addStep("timer not early", ActOut, '0, '0, 32'd1);
        // Output check above used one cycle of the window
        addStep("timer fires", ActWait, '0, TimerAhead, '0);
        addStep("compare readback", ActRead, cp0RegPkg::RegCompare, '0,
                cnt + 32'd1 + TimerAhead);
        addStep("compare ack", ActWrite, cp0RegPkg::RegCompare, '0, '0);
        addStep("timer cleared", ActOut, '0, '0, 32'd1);

        // IP[7:2] follows hwIntI one edge late
        addStep("hw int before", ActHwInt, cp0RegPkg::RegCause, 32'h2d, causeValue());
        ipM[7:2] = 6'h2d;
        addStep("hw int sampled", ActRead, cp0RegPkg::RegCause, '0, causeValue());
        addStep("hw int change", ActHwInt, cp0RegPkg::RegCause, 32'h12, causeValue());
        ipM[7:2] = 6'h12;
        addStep("hw int resampled", ActRead, cp0RegPkg::RegCause, '0, causeValue());
    endfunction

    function automatic void reportMismatch(string name, cp0RegPkg::wordT expVal,
                                           cp0RegPkg::wordT actual);
        errorCount++;
        $display("[FAIL] %s: expected %h, actual %h", name, expVal, actual);
    endfunction

    task automatic applyStep(input stepT s);
        cp0RegPkg::wordT waited;
        waited = '0;
        case (s.act)
            ActWrite: begin
                regAddrI = s.addr;
                wdataI   = s.data;
                writeEnI = 1'b1;
                @(negedge clk);
                writeEnI = 1'b0;
            end
            ActRead: begin
                regAddrI = s.addr;
                #1;
                checkCount++;
                if (rdataO !== s.expVal) reportMismatch(s.name, s.expVal, rdataO);
                @(negedge clk);
            end
            ActExc: begin
                excValidI = 1'b1;
                excKindI  = s.kind;
                pcI       = s.pc;
                inSlotI   = s.inSlot;
                badAddrI  = s.badAddr;
                cpNumI    = s.cpNum;
                if (s.withWrite) begin
                    regAddrI = s.addr;
                    wdataI   = s.data;
                    writeEnI = 1'b1;
                end
                @(negedge clk);
                excValidI = 1'b0;
                writeEnI  = 1'b0;
            end
            ActIdle: repeat (s.data) @(negedge clk);
            ActOut: begin
                #1;
                checkCount++;
                if ({30'd0, timerIntO, usermodeO} !== s.expVal)
                    reportMismatch(s.name, s.expVal, {30'd0, timerIntO, usermodeO});
                @(negedge clk);
            end
            ActWait: begin
                checkCount++;
                while (!timerIntO && waited < s.data) begin
                    @(negedge clk);
                    waited++;
                end
                if (!timerIntO) begin
                    errorCount++;
                    $display("%s: timer interrupt did not rise within %0d cycles",
                             s.name, s.data);
                end
            end
            ActHwInt: begin
                hwIntI   = s.data[cp0RegPkg::HwIntW-1:0];
                regAddrI = s.addr;
                #1;
                checkCount++;
                if (rdataO !== s.expVal) reportMismatch(s.name, s.expVal, rdataO);
                @(negedge clk);
            end
            default: begin
                errorCount++;
                $display("%s: unknown step action %0d", s.name, s.act);
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'h5c60a2cb));
        rst       = 1'b1;
        regAddrI  = '0;
        writeEnI  = 1'b0;
        wdataI    = '0;
        excValidI = 1'b0;
        excKindI  = cp0ExcPkg::ExcIntr;
        pcI       = '0;
        inSlotI   = 1'b0;
        badAddrI  = '0;
        cpNumI    = '0;
        hwIntI    = '0;
        buildTable();
        cycleLimit = 2 * steps.size() + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (steps[i]) applyStep(steps[i]);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/cp0Top.sv */
// CP0 coprocessor top level
`timescale 1ns/1ps

module cp0Top #(
    parameter cp0RegPkg::wordT PrIdValue = 32'h00018000,
    parameter logic [2:0]      K0Reset   = 3'd2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  cp0RegPkg::regAddrT              regAddrI,
    input  logic                            writeEnI,
    input  cp0RegPkg::wordT                 wdataI,
    output cp0RegPkg::wordT                 rdataO,
    input  logic                            excValidI,
    input  cp0ExcPkg::excKindT              excKindI,
    input  cp0RegPkg::wordT                 pcI,
    input  logic                            inSlotI,
    input  cp0RegPkg::wordT                 badAddrI,
    input  cp0ExcPkg::cpNumT                cpNumI,
    input  logic [cp0RegPkg::HwIntW-1:0]    hwIntI,
    output logic                            usermodeO,
    output logic                            timerIntO
);

    logic               exl;
    logic               takeEntry, takeReturn, saveEpc;
    cp0RegPkg::wordT    epcValue;
    logic               bdValue;
    cp0ExcPkg::excCodeT excCode;
    logic               captureBadAddr, captureCe;
    logic               countWe, compareWe;
    cp0RegPkg::wordT    countValue, compareValue;

    cp0ExcDecode u_excDecode (
        .excValidI       (excValidI),
        .excKindI        (excKindI),
        .pcI             (pcI),
        .inSlotI         (inSlotI),
        .exlI            (exl),
        .takeEntryO      (takeEntry),
        .takeReturnO     (takeReturn),
        .saveEpcO        (saveEpc),
        .epcValueO       (epcValue),
        .bdValueO        (bdValue),
        .excCodeO        (excCode),
        .captureBadAddrO (captureBadAddr),
        .captureCeO      (captureCe)
    );

    cp0RegBlock #(
        .PrIdValue (PrIdValue),
        .K0Reset   (K0Reset)
    ) u_regBlock (
        .clk             (clk),
        .rst             (rst),
        .regAddrI        (regAddrI),
        .writeEnI        (writeEnI),
        .wdataI          (wdataI),
        .rdataO          (rdataO),
        .excValidI       (excValidI),
        .badAddrI        (badAddrI),
        .cpNumI          (cpNumI),
        .hwIntI          (hwIntI),
        .takeEntryI      (takeEntry),
        .takeReturnI     (takeReturn),
        .saveEpcI        (saveEpc),
        .epcValueI       (epcValue),
        .bdValueI        (bdValue),
        .excCodeI        (excCode),
        .captureBadAddrI (captureBadAddr),
        .captureCeI      (captureCe),
        .countI          (countValue),
        .compareI        (compareValue),
        .countWeO        (countWe),
        .compareWeO      (compareWe),
        .exlO            (exl),
        .usermodeO       (usermodeO)
    );

    cp0Timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .countWeI   (countWe),
        .compareWeI (compareWe),
        .wdataI     (wdataI),
        .countO     (countValue),
        .compareO   (compareValue),
        .timerIntO  (timerIntO)
    );

endmodule

/* hdl/cp0RegBlock.sv */
// CP0 status and cause register block
`timescale 1ns/1ps

module cp0RegBlock #(
    parameter cp0RegPkg::wordT PrIdValue = 32'h00018000,
    parameter logic [2:0]      K0Reset   = 3'd2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  cp0RegPkg::regAddrT              regAddrI,
    input  logic                            writeEnI,
    input  cp0RegPkg::wordT                 wdataI,
    output cp0RegPkg::wordT                 rdataO,
    input  logic                            excValidI,
    input  cp0RegPkg::wordT                 badAddrI,
    input  cp0ExcPkg::cpNumT                cpNumI,
    input  logic [cp0RegPkg::HwIntW-1:0]    hwIntI,
    input  logic                            takeEntryI,
    input  logic                            takeReturnI,
    input  logic                            saveEpcI,
    input  cp0RegPkg::wordT                 epcValueI,
    input  logic                            bdValueI,
    input  cp0ExcPkg::excCodeT              excCodeI,
    input  logic                            captureBadAddrI,
    input  logic                            captureCeI,
    input  cp0RegPkg::wordT                 countI,
    input  cp0RegPkg::wordT                 compareI,
    output logic                            countWeO,
    output logic                            compareWeO,
    output logic                            exlO,
    output logic                            usermodeO
);

    logic               statusCu0, statusBev, statusUm, statusErl, statusExl, statusIe;
    logic [7:0]         statusIm;
    logic               causeBd, causeIv;
    logic [1:0]         causeCe;
    logic [7:0]         causeIp;
    cp0ExcPkg::excCodeT causeCode;
    cp0RegPkg::wordT    epc;
    cp0RegPkg::wordT    badVAddr;
    logic [2:0]         configK0;

    cp0RegPkg::wordT    statusWord, causeWord, configWord;
    logic               swWrite;

    // Exception strobe blocks the software write
    assign swWrite    = writeEnI && !excValidI;
    assign countWeO   = swWrite && (regAddrI == cp0RegPkg::RegCount);
    assign compareWeO = swWrite && (regAddrI == cp0RegPkg::RegCompare);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            statusCu0 <= cp0RegPkg::StatusResetValue[cp0RegPkg::StatusCu0];
            statusBev <= cp0RegPkg::StatusResetValue[cp0RegPkg::StatusBev];
            statusIm  <= cp0RegPkg::StatusResetValue[cp0RegPkg::StatusImHi:cp0RegPkg::StatusImLo];
            statusUm  <= cp0RegPkg::StatusResetValue[cp0RegPkg::StatusUm];
            statusErl <= cp0RegPkg::StatusResetValue[cp0RegPkg::StatusErl];
            statusExl <= cp0RegPkg::StatusResetValue[cp0RegPkg::StatusExl];
            statusIe  <= cp0RegPkg::StatusResetValue[cp0RegPkg::StatusIe];
            causeBd   <= 1'b0;
            causeCe   <= '0;
            causeIv   <= 1'b0;
            causeIp   <= '0;
            causeCode <= cp0ExcPkg::CodeInt;
            epc       <= '0;
            badVAddr  <= '0;
            configK0  <= K0Reset;
        end else begin
            causeIp[7:2] <= hwIntI;  // Sampled every cycle

            if (takeEntryI) begin
                statusExl <= 1'b1;
                causeCode <= excCodeI;
                if (saveEpcI) begin
                    epc     <= epcValueI;
                    causeBd <= bdValueI;
                end
                if (captureBadAddrI) begin
                    badVAddr <= badAddrI;
                end
                if (captureCeI) begin
                    causeCe <= cpNumI;
                end
            end else if (takeReturnI) begin
                statusExl <= 1'b0;
            end else if (swWrite) begin
                case (regAddrI)
                    cp0RegPkg::RegStatus: begin
                        statusCu0 <= wdataI[cp0RegPkg::StatusCu0];
                        statusBev <= wdataI[cp0RegPkg::StatusBev];
                        statusIm  <= wdataI[cp0RegPkg::StatusImHi:cp0RegPkg::StatusImLo];
                        statusUm  <= wdataI[cp0RegPkg::StatusUm];
                        statusErl <= wdataI[cp0RegPkg::StatusErl];
                        statusExl <= wdataI[cp0RegPkg::StatusExl];
                        statusIe  <= wdataI[cp0RegPkg::StatusIe];
                    end
                    cp0RegPkg::RegCause: begin
                        causeIv      <= wdataI[cp0RegPkg::CauseIv];
                        causeIp[1:0] <= wdataI[cp0RegPkg::CauseIpLo+1:cp0RegPkg::CauseIpLo];
                    end
                    cp0RegPkg::RegEpc:    epc      <= wdataI;
                    cp0RegPkg::RegConfig: configK0 <= wdataI[cp0RegPkg::ConfigK0Hi:cp0RegPkg::ConfigK0Lo];
                    default: ;  // Read-only or timer side
                endcase
            end
        end
    end

    always_comb begin
        statusWord = '0;
        statusWord[cp0RegPkg::StatusCu0] = statusCu0;
        statusWord[cp0RegPkg::StatusBev] = statusBev;
        statusWord[cp0RegPkg::StatusImHi:cp0RegPkg::StatusImLo] = statusIm;
        statusWord[cp0RegPkg::StatusUm]  = statusUm;
        statusWord[cp0RegPkg::StatusErl] = statusErl;
        statusWord[cp0RegPkg::StatusExl] = statusExl;
        statusWord[cp0RegPkg::StatusIe]  = statusIe;

        causeWord = '0;
        causeWord[cp0RegPkg::CauseBd] = causeBd;
        causeWord[cp0RegPkg::CauseCeHi:cp0RegPkg::CauseCeLo] = causeCe;
        causeWord[cp0RegPkg::CauseIv] = causeIv;
        causeWord[cp0RegPkg::CauseIpHi:cp0RegPkg::CauseIpLo] = causeIp;
        causeWord[cp0RegPkg::CauseCodeHi:cp0RegPkg::CauseCodeLo] = causeCode;

        configWord = '0;
        configWord[cp0RegPkg::ConfigM] = 1'b1;  // Config1 present
        configWord[cp0RegPkg::ConfigMtHi:cp0RegPkg::ConfigMtLo] = cp0RegPkg::ConfigMt;
        configWord[cp0RegPkg::ConfigK0Hi:cp0RegPkg::ConfigK0Lo] = configK0;
    end

    always_comb begin
        case (regAddrI)
            cp0RegPkg::RegBadVAddr: rdataO = badVAddr;
            cp0RegPkg::RegCount:    rdataO = countI;
            cp0RegPkg::RegCompare:  rdataO = compareI;
            cp0RegPkg::RegStatus:   rdataO = statusWord;
            cp0RegPkg::RegCause:    rdataO = causeWord;
            cp0RegPkg::RegEpc:      rdataO = epc;
            cp0RegPkg::RegPrId:     rdataO = PrIdValue;
            cp0RegPkg::RegConfig:   rdataO = configWord;
            default:                rdataO = '0;
        endcase
    end

    assign exlO      = statusExl;
    assign usermodeO = statusUm && !(statusErl || statusExl);

    // Decoder must save EPC exactly when entry finds EXL clear
    assertEpcSaveMatchesExl: assert property (
        @(posedge clk) disable iff (rst)
        takeEntryI |-> (saveEpcI == !exlO)
    ) else $error("EPC save decision disagrees with EXL");

endmodule

/* hdl/cp0Timer.sv */
// CP0 count and compare timer
`timescale 1ns/1ps

module cp0Timer (
    input  logic             clk,
    input  logic             rst,
    input  logic             countWeI,
    input  logic             compareWeI,
    input  cp0RegPkg::wordT  wdataI,
    output cp0RegPkg::wordT  countO,
    output cp0RegPkg::wordT  compareO,
    output logic             timerIntO
);

    cp0RegPkg::wordT count;
    cp0RegPkg::wordT compare;
    logic            timerInt;
    logic            match;

    // Zero Compare means timer disabled
    assign match = (compare != '0) && (count == compare);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count    <= '0;
            compare  <= '0;
            timerInt <= 1'b0;
        end else begin
            if (countWeI) begin
                count <= wdataI;
            end else begin
                count <= count + 32'd1;  // Free running
            end

            if (compareWeI) begin
                compare  <= wdataI;
                timerInt <= 1'b0;  // Acknowledge
            end else if (match) begin
                timerInt <= 1'b1;
            end
        end
    end

    assign countO    = count;
    assign compareO  = compare;
    assign timerIntO = timerInt;

    // Both strobes share one data word
    assertOneTimerWrite: assert property (
        @(posedge clk) disable iff (rst)
        !(countWeI && compareWeI)
    ) else $error("Count and Compare written in the same cycle");

endmodule

/* hdl/cp0ExcDecode.sv */
// CP0 exception decoder
`timescale 1ns/1ps

module cp0ExcDecode (
    input  logic                excValidI,
    input  cp0ExcPkg::excKindT  excKindI,
    input  cp0RegPkg::wordT     pcI,
    input  logic                inSlotI,
    input  logic                exlI,
    output logic                takeEntryO,
    output logic                takeReturnO,
    output logic                saveEpcO,
    output cp0RegPkg::wordT     epcValueO,
    output logic                bdValueO,
    output cp0ExcPkg::excCodeT  excCodeO,
    output logic                captureBadAddrO,
    output logic                captureCeO
);

    logic               isEntry;
    logic               isAddrErr;
    cp0ExcPkg::excCodeT code;

    always_comb begin
        isEntry = 1'b1;
        code    = cp0ExcPkg::CodeInt;
        case (excKindI)
            cp0ExcPkg::ExcIntr:    code = cp0ExcPkg::CodeInt;
            cp0ExcPkg::ExcCpU:     code = cp0ExcPkg::CodeCpU;
            cp0ExcPkg::ExcRi:      code = cp0ExcPkg::CodeRi;
            cp0ExcPkg::ExcOv:      code = cp0ExcPkg::CodeOv;
            cp0ExcPkg::ExcTrap:    code = cp0ExcPkg::CodeTr;
            cp0ExcPkg::ExcSysCall: code = cp0ExcPkg::CodeSys;
            cp0ExcPkg::ExcBp:      code = cp0ExcPkg::CodeBp;
            cp0ExcPkg::ExcAdEL:    code = cp0ExcPkg::CodeAdEL;
            cp0ExcPkg::ExcAdES:    code = cp0ExcPkg::CodeAdES;
            default:               isEntry = 1'b0;  // ERET and spare encodings
        endcase
    end

    assign isAddrErr = (excKindI == cp0ExcPkg::ExcAdEL) || (excKindI == cp0ExcPkg::ExcAdES);

    assign takeEntryO  = excValidI && isEntry;
    assign takeReturnO = excValidI && (excKindI == cp0ExcPkg::ExcEret);

    // Nested exception keeps the first EPC
    assign saveEpcO = takeEntryO && !exlI;

    // Delay slot restarts at the branch
    assign epcValueO = inSlotI ? (pcI - 32'd4) : pcI;
    assign bdValueO  = inSlotI;
    assign excCodeO  = code;

    assign captureBadAddrO = takeEntryO && isAddrErr;
    assign captureCeO      = takeEntryO && (excKindI == cp0ExcPkg::ExcCpU);

    // A valid strobe is exactly one of entry and ERET
    always_comb begin
        assert (!excValidI || (takeEntryO != takeReturnO))
            else $error("Exception strobe decoded as neither or both of entry and ERET");
    end

endmodule

/* hdl/cp0ExcPkg.sv */
// CP0 exception kinds and codes
package cp0ExcPkg;

    // Exception kinds seen on the pipeline side
    typedef enum logic [3:0] {
        ExcIntr,
        ExcCpU,
        ExcRi,
        ExcOv,
        ExcTrap,
        ExcSysCall,
        ExcBp,
        ExcAdEL,
        ExcAdES,
        ExcEret
    } excKindT;

    // Architectural ExcCode values for Cause
    typedef enum logic [4:0] {
        CodeInt  = 5'd0,
        CodeAdEL = 5'd4,
        CodeAdES = 5'd5,
        CodeSys  = 5'd8,
        CodeBp   = 5'd9,
        CodeRi   = 5'd10,
        CodeCpU  = 5'd11,
        CodeOv   = 5'd12,
        CodeTr   = 5'd13
    } excCodeT;

    typedef logic [1:0] cpNumT;

endpackage

/* hdl/cp0RegPkg.sv */
// CP0 register map
package cp0RegPkg;

    typedef logic [4:0]  regAddrT;
    typedef logic [31:0] wordT;

    // Register numbers
    localparam regAddrT RegBadVAddr = 5'd8;
    localparam regAddrT RegCount    = 5'd9;
    localparam regAddrT RegCompare  = 5'd11;
    localparam regAddrT RegStatus   = 5'd12;
    localparam regAddrT RegCause    = 5'd13;
    localparam regAddrT RegEpc      = 5'd14;
    localparam regAddrT RegPrId     = 5'd15;
    localparam regAddrT RegConfig   = 5'd16;

    // Status fields
    localparam int StatusCu0  = 28;
    localparam int StatusBev  = 22;
    localparam int StatusImHi = 15;
    localparam int StatusImLo = 8;
    localparam int StatusUm   = 4;
    localparam int StatusErl  = 2;
    localparam int StatusExl  = 1;
    localparam int StatusIe   = 0;

    // Cause fields
    localparam int CauseBd     = 31;
    localparam int CauseCeHi   = 29;
    localparam int CauseCeLo   = 28;
    localparam int CauseIv     = 23;
    localparam int CauseIpHi   = 15;
    localparam int CauseIpLo   = 8;
    localparam int CauseCodeHi = 6;
    localparam int CauseCodeLo = 2;

    // Config fields
    localparam int         ConfigM    = 31;
    localparam int         ConfigMtHi = 9;
    localparam int         ConfigMtLo = 7;
    localparam int         ConfigK0Hi = 2;
    localparam int         ConfigK0Lo = 0;
    localparam logic [2:0] ConfigMt   = 3'd1;  // Standard TLB

    localparam int HwIntW = 6;

    localparam wordT StatusResetValue = 32'h00400004;  // BEV and ERL set

endpackage
